//--- logic/opmux_config.svh
// ================================================
// Widths and constants of the operand decoder.
// Data words are 32 bits and instruction words 16.
// The widths here set the package types, so change
// them together with the decoder rules.
// ================================================

`ifndef OPMUX_CONFIG_SVH
`define OPMUX_CONFIG_SVH

// Word widths.
`define OPMUX_DATA_W      32
`define OPMUX_WORD_W      16

// Bit-field and address widths.
`define OPMUX_BF_WIDTH_W  6
`define OPMUX_BITPOS_W    5
`define OPMUX_MAIN_OFS_W  6

// A coded zero width selects the full field.
`define OPMUX_FULL_FIELD  32
// A quick field of zero stands for eight.
`define OPMUX_QUICK_EIGHT 8

`endif

//--- logic/opmux_pkg.sv
// ================================================
// Shared types of the operand decoder.
// Vector widths follow the config header.
// Only six operation classes are decoded.
// ================================================

`include "opmux_config.svh"

package opmux_pkg;

    // Plain vectors with a meaning.
    typedef logic [`OPMUX_DATA_W-1:0]     data_t;
    typedef logic [`OPMUX_WORD_W-1:0]     word_t;
    typedef logic [`OPMUX_BF_WIDTH_W-1:0] bf_width_t;
    typedef logic [`OPMUX_BITPOS_W-1:0]   bitpos_t;
    typedef logic [`OPMUX_MAIN_OFS_W-1:0] main_ofs_t;
    // Mode zero is data register direct.
    typedef logic [2:0]                   adr_mode_t;

    // Reduced operation classes.
    typedef enum logic [2:0] {
        OP_QUICK     = 3'd0,
        OP_MOVEQ     = 3'd1,
        OP_IMM_ALU   = 3'd2,
        OP_BIT       = 3'd3,
        OP_BIT_FIELD = 3'd4,
        OP_OTHER     = 3'd5
    } op_class_t;

    // Operand size, as in the 68k size field.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_WORD = 2'd1,
        SIZE_LONG = 2'd2
    } op_size_t;

    // Input side handshake.
    typedef enum logic [1:0] {
        CAP_IDLE         = 2'd0,
        CAP_WAIT_RELEASE = 2'd1
    } capture_state_t;

    // Output side handshake.
    typedef enum logic [1:0] {
        SEND_IDLE         = 2'd0,
        SEND_WAIT_ACK     = 2'd1,
        SEND_WAIT_RELEASE = 2'd2
    } send_state_t;

endpackage

//--- logic/operand_capture.sv
// ================================================
// Four-phase slave on the input side.
// The context is stored only at the accepting edge.
// A request waits while the output side is busy.
// The host holds in_req low until in_ack drops.
// ================================================

`timescale 1ns/1ps
`include "opmux_config.svh"

module operand_capture (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 in_req,
    output logic                 in_ack,
    input  logic                 busy,
    input  opmux_pkg::op_class_t op_class_in,
    input  opmux_pkg::op_size_t  op_size_in,
    input  opmux_pkg::word_t     biw_0_in,
    input  opmux_pkg::word_t     biw_1_in,
    input  opmux_pkg::word_t     biw_2_in,
    input  opmux_pkg::data_t     dr_value_in,
    input  opmux_pkg::adr_mode_t adr_mode_in,
    input  opmux_pkg::main_ofs_t adr_offset_main_in,
    output logic                 load,
    output opmux_pkg::op_class_t op_class,
    output opmux_pkg::op_size_t  op_size,
    output opmux_pkg::word_t     biw_0,
    output opmux_pkg::word_t     biw_1,
    output opmux_pkg::word_t     biw_2,
    output opmux_pkg::data_t     dr_value,
    output opmux_pkg::adr_mode_t adr_mode,
    output opmux_pkg::main_ofs_t adr_offset_main
);
    import opmux_pkg::*;

    capture_state_t state;
    logic           accept;

    // Accept only when idle and the sender is free.
    assign accept = (state == CAP_IDLE) && in_req && !busy;

    // ================================================
    // Handshake FSM.
    // ================================================
    always_ff @(posedge CLK) begin
        if (reset) begin
            state  <= CAP_IDLE;
            in_ack <= 1'b0;
            load   <= 1'b0;
        end else begin
            // Load is a single cycle pulse.
            load <= accept;
            case (state)
                CAP_IDLE: begin
                    if (accept) begin
                        in_ack <= 1'b1;
                        state  <= CAP_WAIT_RELEASE;
                    end
                end
                CAP_WAIT_RELEASE: begin
                    // Release once the host drops its request.
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Held context, stable until the next accept.
    always_ff @(posedge CLK) begin
        if (accept) begin
            op_class        <= op_class_in;
            op_size         <= op_size_in;
            biw_0           <= biw_0_in;
            biw_1           <= biw_1_in;
            biw_2           <= biw_2_in;
            dr_value        <= dr_value_in;
            adr_mode        <= adr_mode_in;
            adr_offset_main <= adr_offset_main_in;
        end
    end

endmodule

//--- logic/immediate_decode.sv
// ================================================
// Immediate operand decoder, combinational.
// Only quick, MOVEQ and sized ALU immediates are
// formed. All other classes yield zero.
// Values are zero-extended, never sign-extended.
// ================================================

`timescale 1ns/1ps
`include "opmux_config.svh"

module immediate_decode (
    input  opmux_pkg::op_class_t op_class,
    input  opmux_pkg::op_size_t  op_size,
    input  opmux_pkg::word_t     biw_0,
    input  opmux_pkg::word_t     biw_1,
    input  opmux_pkg::word_t     biw_2,
    output opmux_pkg::data_t     data_immediate
);
    import opmux_pkg::*;

    // Quick field of ADDQ and SUBQ.
    logic [2:0] quick_field;
    // Sized immediate from the extension words.
    data_t      sized_imm;

    assign quick_field = biw_0[11:9];

    // ================================================
    // Sized immediate.
    // ================================================
    always_comb begin
        case (op_size)
            // Long spans both extension words, high word first.
            SIZE_LONG: sized_imm = {biw_1, biw_2};
            SIZE_WORD: sized_imm = data_t'(biw_1);
            // Byte sits in the low half of the first extension.
            default:   sized_imm = data_t'(biw_1[7:0]);
        endcase
    end

    // ================================================
    // Class select.
    // ================================================
    always_comb begin
        case (op_class)
            OP_QUICK: begin
                // Coded zero means eight.
                if (quick_field == 3'd0)
                    data_immediate = data_t'(`OPMUX_QUICK_EIGHT);
                else
                    data_immediate = data_t'(quick_field);
            end
            OP_MOVEQ:   data_immediate = data_t'(biw_0[7:0]);
            OP_IMM_ALU: data_immediate = sized_imm;
            default:    data_immediate = '0;
        endcase
    end

endmodule

//--- logic/bit_field_decode.sv
// ================================================
// Bit-field and bit position decoder, combinational.
// Memory modes limit the bit position to 0..7.
// The byte offset treats the field offset as signed
// and the main offset as unsigned.
// ================================================

`timescale 1ns/1ps
`include "opmux_config.svh"

module bit_field_decode (
    input  opmux_pkg::op_class_t op_class,
    input  opmux_pkg::word_t     biw_0,
    input  opmux_pkg::word_t     biw_1,
    input  opmux_pkg::data_t     dr_value,
    input  opmux_pkg::adr_mode_t adr_mode,
    input  opmux_pkg::main_ofs_t adr_offset_main,
    output opmux_pkg::data_t     bf_offset,
    output opmux_pkg::bf_width_t bf_width,
    output opmux_pkg::bitpos_t   bitpos,
    output opmux_pkg::data_t     adr_offset
);
    import opmux_pkg::*;

    logic [4:0] width_code;
    data_t      bitpos_src;
    data_t      byte_ofs;

    // ================================================
    // Field offset and width.
    // ================================================

    // Bit 11 of the extension picks Dn as the offset.
    assign bf_offset = biw_1[11] ? dr_value : data_t'(biw_1[10:6]);

    // Bit 5 of the extension picks Dn as the width.
    assign width_code = biw_1[5] ? dr_value[4:0] : biw_1[4:0];

    // A zero width code means a full 32-bit field.
    assign bf_width = (width_code == 5'd0) ? bf_width_t'(`OPMUX_FULL_FIELD)
                                           : bf_width_t'(width_code);

    // ================================================
    // Bit position.
    // ================================================
    always_comb begin
        if (op_class == OP_BIT) begin
            // Dynamic form takes Dn, static form the extension.
            bitpos_src = biw_0[8] ? dr_value : data_t'(biw_1);
        end else begin
            // Bit-field ops use the field offset source.
            bitpos_src = bf_offset;
        end
    end

    // Register direct uses five bits, memory only three.
    assign bitpos = (adr_mode == '0) ? bitpos_src[`OPMUX_BITPOS_W-1:0]
                                     : bitpos_t'(bitpos_src[2:0]);

    // ================================================
    // Address offset.
    // ================================================

    // Signed bit offset to a byte offset.
    assign byte_ofs = data_t'($signed(bf_offset) >>> 3);

    always_comb begin
        if (op_class == OP_BIT_FIELD)
            adr_offset = byte_ofs + data_t'(adr_offset_main);
        else
            adr_offset = data_t'(adr_offset_main);
    end

endmodule

//--- logic/result_sender.sv
// ================================================
// Four-phase master on the output side.
// Results are registered at the end of the load
// cycle and held until the next load.
// Only one transaction is in flight at a time.
// ================================================

`timescale 1ns/1ps
`include "opmux_config.svh"

module result_sender (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 load,
    output logic                 busy,
    input  opmux_pkg::data_t     data_immediate_in,
    input  opmux_pkg::data_t     bf_offset_in,
    input  opmux_pkg::data_t     adr_offset_in,
    input  opmux_pkg::bf_width_t bf_width_in,
    input  opmux_pkg::bitpos_t   bitpos_in,
    output logic                 out_req,
    input  logic                 out_ack,
    output opmux_pkg::data_t     data_immediate,
    output opmux_pkg::data_t     bf_offset,
    output opmux_pkg::bf_width_t bf_width,
    output opmux_pkg::bitpos_t   bitpos,
    output opmux_pkg::data_t     adr_offset
);
    import opmux_pkg::*;

    send_state_t state;

    // Busy also covers the load cycle itself.
    assign busy = (state != SEND_IDLE) || load;

    // ================================================
    // Handshake FSM.
    // ================================================
    always_ff @(posedge CLK) begin
        if (reset) begin
            state   <= SEND_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                SEND_IDLE: begin
                    if (load) begin
                        out_req <= 1'b1;
                        state   <= SEND_WAIT_ACK;
                    end
                end
                SEND_WAIT_ACK: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= SEND_WAIT_RELEASE;
                    end
                end
                SEND_WAIT_RELEASE: begin
                    // Consumer must drop its ack first.
                    if (!out_ack)
                        state <= SEND_IDLE;
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    // Result registers.
    always_ff @(posedge CLK) begin
        if (load) begin
            data_immediate <= data_immediate_in;
            bf_offset      <= bf_offset_in;
            bf_width       <= bf_width_in;
            bitpos         <= bitpos_in;
            adr_offset     <= adr_offset_in;
        end
    end

endmodule

//--- logic/operand_mux_top.sv
// ================================================
// Bit-field and immediate operand decoder, top.
// Request to result latency is one cycle from the
// accepting edge. The consumer may stall out_ack.
// ================================================

`timescale 1ns/1ps

module operand_mux_top (
    input  logic                 CLK,
    input  logic                 reset,
    // Input side.
    input  logic                 in_req,
    output logic                 in_ack,
    input  opmux_pkg::op_class_t op_class,
    input  opmux_pkg::op_size_t  op_size,
    input  opmux_pkg::word_t     biw_0,
    input  opmux_pkg::word_t     biw_1,
    input  opmux_pkg::word_t     biw_2,
    input  opmux_pkg::data_t     dr_value,
    input  opmux_pkg::adr_mode_t adr_mode,
    input  opmux_pkg::main_ofs_t adr_offset_main,
    // Output side.
    output logic                 out_req,
    input  logic                 out_ack,
    output opmux_pkg::data_t     data_immediate,
    output opmux_pkg::data_t     bf_offset,
    output opmux_pkg::bf_width_t bf_width,
    output opmux_pkg::bitpos_t   bitpos,
    output opmux_pkg::data_t     adr_offset
);
    import opmux_pkg::*;

    // Handshake between the two sides.
    logic      load;
    logic      busy;

    // Held context.
    op_class_t cap_op_class;
    op_size_t  cap_op_size;
    word_t     cap_biw_0;
    word_t     cap_biw_1;
    word_t     cap_biw_2;
    data_t     cap_dr_value;
    adr_mode_t cap_adr_mode;
    main_ofs_t cap_adr_offset_main;

    // Decoded results, before the output registers.
    data_t     dec_immediate;
    data_t     dec_bf_offset;
    bf_width_t dec_bf_width;
    bitpos_t   dec_bitpos;
    data_t     dec_adr_offset;

    operand_capture u_capture (
        .CLK(CLK), .reset(reset), .in_req(in_req), .in_ack(in_ack), .busy(busy),
        .op_class_in(op_class), .op_size_in(op_size), .biw_0_in(biw_0),
        .biw_1_in(biw_1), .biw_2_in(biw_2), .dr_value_in(dr_value),
        .adr_mode_in(adr_mode), .adr_offset_main_in(adr_offset_main), .load(load),
        .op_class(cap_op_class), .op_size(cap_op_size), .biw_0(cap_biw_0),
        .biw_1(cap_biw_1), .biw_2(cap_biw_2), .dr_value(cap_dr_value),
        .adr_mode(cap_adr_mode), .adr_offset_main(cap_adr_offset_main)
    );

    immediate_decode u_immediate (
        .op_class(cap_op_class), .op_size(cap_op_size), .biw_0(cap_biw_0),
        .biw_1(cap_biw_1), .biw_2(cap_biw_2), .data_immediate(dec_immediate)
    );

    bit_field_decode u_bit_field (
        .op_class(cap_op_class), .biw_0(cap_biw_0), .biw_1(cap_biw_1),
        .dr_value(cap_dr_value), .adr_mode(cap_adr_mode),
        .adr_offset_main(cap_adr_offset_main), .bf_offset(dec_bf_offset),
        .bf_width(dec_bf_width), .bitpos(dec_bitpos), .adr_offset(dec_adr_offset)
    );

    result_sender u_sender (
        .CLK(CLK), .reset(reset), .load(load), .busy(busy),
        .data_immediate_in(dec_immediate), .bf_offset_in(dec_bf_offset),
        .adr_offset_in(dec_adr_offset), .bf_width_in(dec_bf_width),
        .bitpos_in(dec_bitpos), .out_req(out_req), .out_ack(out_ack),
        .data_immediate(data_immediate), .bf_offset(bf_offset),
        .bf_width(bf_width), .bitpos(bitpos), .adr_offset(adr_offset)
    );

endmodule

//--- test/tb_operand_mux.sv
// ================================================
// Testbench of the operand decoder.
// Inputs change on the falling edge, outputs are
// sampled on the falling edge where they are stable.
// One consumer acks each result after ack_delay
// cycles. Every wait gives up after TIMEOUT_CYCLES.
// ================================================

`timescale 1ns/1ps
`include "opmux_config.svh"

module tb_operand_mux;
    import opmux_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    // Expected results of one transaction.
    typedef struct packed {
        data_t     imm;
        data_t     bf_offset;
        bf_width_t bf_width;
        bitpos_t   bitpos;
        data_t     adr_offset;
    } result_t;

    logic      CLK;
    logic      reset;
    logic      in_req;
    logic      in_ack;
    op_class_t op_class;
    op_size_t  op_size;
    word_t     biw_0;
    word_t     biw_1;
    word_t     biw_2;
    data_t     dr_value;
    adr_mode_t adr_mode;
    main_ofs_t adr_offset_main;
    logic      out_req;
    logic      out_ack;
    data_t     data_immediate;
    data_t     bf_offset;
    bf_width_t bf_width;
    bitpos_t   bitpos;
    data_t     adr_offset;

    // Results still owed by the DUT, oldest first.
    result_t expected_q[$];

    int cycle_count = 0;
    int ack_cycle   = 0;
    int ack_delay   = 1;
    int checks_run  = 0;
    int error_count = 0;
    int test_checks = 0;
    int test_errors = 0;

    operand_mux_top UUT (
        .CLK(CLK), .reset(reset), .in_req(in_req), .in_ack(in_ack),
        .op_class(op_class), .op_size(op_size), .biw_0(biw_0), .biw_1(biw_1),
        .biw_2(biw_2), .dr_value(dr_value), .adr_mode(adr_mode),
        .adr_offset_main(adr_offset_main), .out_req(out_req), .out_ack(out_ack),
        .data_immediate(data_immediate), .bf_offset(bf_offset), .bf_width(bf_width),
        .bitpos(bitpos), .adr_offset(adr_offset)
    );

    // 100 ns clock.
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Edge count, used for the latency check.
    always @(posedge CLK) cycle_count <= cycle_count + 1;

    // ================================================
    // Reference model.
    // ================================================

    // Bit-field extension word.
    function automatic word_t bf_ext(input logic reg_ofs, input logic [4:0] ofs,
                                     input logic reg_w, input logic [4:0] w);
        return {4'b0000, reg_ofs, ofs, reg_w, w};
    endfunction

    function automatic result_t expected_results(
        input op_class_t cls, input op_size_t sz, input word_t w0, input word_t w1,
        input word_t w2, input data_t dr, input adr_mode_t mode, input main_ofs_t main_ofs);
        result_t            r;
        logic [4:0]         wc;
        data_t              src;
        logic signed [31:0] ofs_s;
        r.imm = 32'h0000_0000;
        case (cls)
            OP_QUICK:   r.imm = (w0[11:9] == 3'd0) ? 32'd8 : {29'd0, w0[11:9]};
            OP_MOVEQ:   r.imm = {24'd0, w0[7:0]};
            OP_IMM_ALU: begin
                if (sz == SIZE_LONG)
                    r.imm = {w1, w2};
                else if (sz == SIZE_WORD)
                    r.imm = {16'd0, w1};
                else
                    r.imm = {24'd0, w1[7:0]};
            end
            default:    r.imm = 32'h0000_0000;
        endcase
        // Field offset and width, register or immediate.
        r.bf_offset = w1[11] ? dr : {27'd0, w1[10:6]};
        wc = w1[5] ? dr[4:0] : w1[4:0];
        r.bf_width = (wc == 5'd0) ? 6'd32 : {1'b0, wc};
        // Bit position source and its width.
        if (cls == OP_BIT)
            src = w0[8] ? dr : {16'd0, w1};
        else
            src = r.bf_offset;
        r.bitpos = (mode == 3'd0) ? src[4:0] : {2'b00, src[2:0]};
        // Byte offset rounds toward minus infinity.
        ofs_s = signed'(r.bf_offset);
        if (cls == OP_BIT_FIELD)
            r.adr_offset = data_t'(ofs_s >>> 3) + {26'd0, main_ofs};
        else
            r.adr_offset = {26'd0, main_ofs};
        return r;
    endfunction

    // ================================================
    // Check and wait helpers.
    // ================================================
    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        checks_run++;
        assert (actv === expv) else begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
            error_count++;
        end
    endtask

    // Present one context and raise in_req.
    task automatic start_request(input op_class_t cls, input op_size_t sz, input word_t w0,
                                 input word_t w1, input word_t w2, input data_t dr,
                                 input adr_mode_t mode, input main_ofs_t main_ofs);
        @(negedge CLK);
        op_class        = cls;
        op_size         = sz;
        biw_0           = w0;
        biw_1           = w1;
        biw_2           = w2;
        dr_value        = dr;
        adr_mode        = mode;
        adr_offset_main = main_ofs;
        in_req          = 1'b1;
        expected_q.push_back(expected_results(cls, sz, w0, w1, w2, dr, mode, main_ofs));
    endtask

    // Finish the input handshake.
    task automatic finish_request();
        int n;
        n = 0;
        while (in_ack !== 1'b1) begin
            @(negedge CLK);
            n++;
            if (n > TIMEOUT_CYCLES) abort_on_timeout("in_ack never rose for a request");
        end
        in_req = 1'b0;
        n = 0;
        while (in_ack !== 1'b0) begin
            @(negedge CLK);
            n++;
            if (n > TIMEOUT_CYCLES) abort_on_timeout("in_ack stayed high after in_req fell");
        end
    endtask

    task automatic send_context(input op_class_t cls, input op_size_t sz, input word_t w0,
                                input word_t w1, input word_t w2, input data_t dr,
                                input adr_mode_t mode, input main_ofs_t main_ofs);
        start_request(cls, sz, w0, w1, w2, dr, mode, main_ofs);
        finish_request();
    endtask

    task automatic send_random();
        op_class_t cls;
        op_size_t  sz;
        cls = op_class_t'(3'($urandom % 6));
        sz  = op_size_t'(2'($urandom % 3));
        send_context(cls, sz, word_t'($urandom), word_t'($urandom), word_t'($urandom),
                     $urandom, adr_mode_t'($urandom), main_ofs_t'($urandom));
    endtask

    // Wait until every result has been delivered and released.
    task automatic wait_idle();
        int n;
        n = 0;
        while (expected_q.size() != 0 || out_req !== 1'b0 || out_ack !== 1'b0) begin
            @(negedge CLK);
            n++;
            if (n > TIMEOUT_CYCLES) abort_on_timeout("results not drained");
        end
        @(negedge CLK);
    endtask

    task automatic end_test(input string name);
        wait_idle();
        $display("Test %-14s %0d checks, %0d errors", name,
                 checks_run - test_checks, error_count - test_errors);
        test_checks = checks_run;
        test_errors = error_count;
    endtask

    // ================================================
    // Response monitor.
    // ================================================
    initial begin : response_monitor
        logic    prev_req;
        logic    prev_ack;
        result_t want;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        forever begin
            @(negedge CLK);
            if (in_ack === 1'b1 && prev_ack !== 1'b1)
                ack_cycle = cycle_count;
            if (out_req === 1'b1 && prev_req !== 1'b1) begin
                checks_run++;
                assert (expected_q.size() != 0) else begin
                    $display("Error at %0t ns: out_req rose with no request pending", $time);
                    error_count++;
                end
                if (expected_q.size() != 0) begin
                    want = expected_q.pop_front();
                    compare_value("data_immediate", want.imm, data_immediate);
                    compare_value("bf_offset", want.bf_offset, bf_offset);
                    compare_value("bf_width", 32'(want.bf_width), 32'(bf_width));
                    compare_value("bitpos", 32'(want.bitpos), 32'(bitpos));
                    compare_value("adr_offset", want.adr_offset, adr_offset);
                    // One edge from in_ack to out_req.
                    compare_value("out_req rise cycle", 32'(ack_cycle + 1), 32'(cycle_count));
                end
            end
            prev_req = out_req;
            prev_ack = in_ack;
        end
    end

    // Consumer, acks after ack_delay cycles.
    initial begin : consumer
        int n;
        out_ack = 1'b0;
        forever begin
            @(negedge CLK);
            if (out_req === 1'b1) begin
                repeat (ack_delay) @(negedge CLK);
                out_ack = 1'b1;
                n = 0;
                while (out_req !== 1'b0) begin
                    @(negedge CLK);
                    n++;
                    if (n > TIMEOUT_CYCLES) abort_on_timeout("out_req stayed high after out_ack");
                end
                out_ack = 1'b0;
            end
        end
    end

    // ================================================
    // Stimulus.
    // ================================================
    initial begin : stimulus
        int blocked;
        void'($urandom(60));
        reset           = 1'b1;
        in_req          = 1'b0;
        op_class        = OP_OTHER;
        op_size         = SIZE_BYTE;
        biw_0           = '0;
        biw_1           = '0;
        biw_2           = '0;
        dr_value        = '0;
        adr_mode        = '0;
        adr_offset_main = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        @(negedge CLK);
        compare_value("in_ack", 32'd0, 32'(in_ack));
        compare_value("out_req", 32'd0, 32'(out_req));
        end_test("reset_state");

        // Quick zero and nonzero, MOVEQ, ALU sizes, other.
        send_context(OP_QUICK, SIZE_LONG, 16'h5000, 16'h0000, 16'h0000, 32'h0, 3'd0, 6'd0);
        send_context(OP_QUICK, SIZE_WORD, 16'h5A00, 16'h1234, 16'h0000, 32'h7, 3'd0, 6'd1);
        send_context(OP_MOVEQ, SIZE_LONG, 16'h70F3, 16'h0000, 16'h0000, 32'h0, 3'd0, 6'd2);
        send_context(OP_IMM_ALU, SIZE_LONG, 16'h0C80, 16'hDEAD, 16'hBEEF, 32'h0, 3'd7, 6'd3);
        send_context(OP_IMM_ALU, SIZE_WORD, 16'h0C40, 16'h8001, 16'hFFFF, 32'h0, 3'd7, 6'd4);
        send_context(OP_IMM_ALU, SIZE_BYTE, 16'h0C00, 16'h12A5, 16'hFFFF, 32'h0, 3'd7, 6'd5);
        send_context(OP_OTHER, SIZE_LONG, 16'hFFFF, 16'hFFFF, 16'hFFFF, 32'h0, 3'd0, 6'd6);
        end_test("immediates");

        // Width and offset from the extension and from Dn.
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8C0, bf_ext(0, 13, 0, 7), 16'h0,
                     32'h0, 3'd0, 6'd0);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8C0, bf_ext(0, 3, 0, 0), 16'h0,
                     32'h0, 3'd0, 6'd0);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8C0, bf_ext(1, 0, 1, 0), 16'h0,
                     32'h0000_0123, 3'd0, 6'd0);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8C0, bf_ext(0, 9, 1, 0), 16'h0,
                     32'h0000_0040, 3'd0, 6'd0);
        end_test("bf_width_offset");

        // Bit position, register direct and memory.
        send_context(OP_BIT, SIZE_LONG, 16'h0100, 16'h0000, 16'h0, 32'h0000_001D, 3'd0, 6'd0);
        send_context(OP_BIT, SIZE_LONG, 16'h0800, 16'h001E, 16'h0, 32'h0000_0003, 3'd0, 6'd0);
        send_context(OP_BIT, SIZE_BYTE, 16'h0100, 16'h0000, 16'h0, 32'h0000_001D, 3'd2, 6'd0);
        send_context(OP_BIT, SIZE_BYTE, 16'h0800, 16'h000F, 16'h0, 32'h0000_0000, 3'd5, 6'd0);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8C0, bf_ext(0, 27, 0, 4), 16'h0,
                     32'h0, 3'd0, 6'd2);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8D0, bf_ext(0, 27, 0, 4), 16'h0,
                     32'h0, 3'd2, 6'd2);
        // Negative register offsets reach bytes below the base.
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8D0, bf_ext(1, 0, 0, 8), 16'h0,
                     32'hFFFF_FFFF, 3'd2, 6'd5);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8D0, bf_ext(1, 0, 0, 8), 16'h0,
                     32'hFFFF_FFEC, 3'd2, 6'd10);
        send_context(OP_BIT_FIELD, SIZE_LONG, 16'hE8D0, bf_ext(1, 0, 0, 8), 16'h0,
                     32'hFFFF_FF9C, 3'd5, 6'd0);
        end_test("bit_position");

        // Stalled consumer must block the next request.
        ack_delay = 10 + int'($urandom % 10);
        send_context(OP_IMM_ALU, SIZE_LONG, 16'h0C80, 16'hCAFE, 16'hF00D, 32'h0, 3'd7, 6'd9);
        start_request(OP_BIT_FIELD, SIZE_LONG, 16'hE8D0, bf_ext(1, 0, 1, 0), 16'h0,
                      $urandom, 3'd2, 6'd17);
        blocked = 0;
        while (out_ack !== 1'b1) begin
            @(negedge CLK);
            compare_value("in_ack", 32'd0, 32'(in_ack));
            blocked++;
            if (blocked > TIMEOUT_CYCLES) abort_on_timeout("out_ack never rose on a stall");
        end
        finish_request();
        end_test("back_pressure");

        // Random traffic, latency checked on every result.
        for (int i = 0; i < 200; i++) begin
            ack_delay = int'($urandom % 4);
            send_random();
        end
        end_test("latency");

        $display("Summary: %0d checks, %0d errors", checks_run, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/opmux_pkg.sv
logic/operand_capture.sv
logic/immediate_decode.sv
logic/bit_field_decode.sv
logic/result_sender.sv
logic/operand_mux_top.sv
test/tb_operand_mux.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_operand_mux -o sim_operand_mux

output=$(./obj_dir/sim_operand_mux)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi
